//--- Makefile
# Verilator simulation of the node control block, run from the project root
TOP    ?= node_tb
SEED   ?= 1
BUILD  ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS   := Finished with no errors

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f compile.f
	@out="$$(./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD)

//--- bench/node_tb.sv
/*
 * Testbench for node_top. Reads bench/node_tests.txt from the project root.
 * The core is modeled as plain output levels. The node sits at row 2, column 3.
 * Loopback updates are tracked in the input model through EXPIN lines only.
 */
`timescale 1ns/1ps

module node_tb;

    localparam int         INPUTS      = 8;
    localparam int         OUTPUTS     = 8;
    localparam int         STORE_DEPTH = 32;
    localparam int         CMD_CYCLES  = 200; // Watchdog budget per command
    localparam string      TESTS_FILE  = "bench/node_tests.txt";
    localparam logic [3:0] OWN_ROW     = 4'h2;
    localparam logic [3:0] OWN_COL     = 4'h3;

    logic                    clk, arst_n;
    logic                    trigger, map_valid, sig_valid, msg_ready;
    node_msg_pkg::map_req_t  map;
    node_msg_pkg::sig_upd_t  sig;
    logic [OUTPUTS-1:0]      core_outputs;
    logic                    core_trigger, idle, msg_valid;
    logic [INPUTS-1:0]       core_inputs;
    node_msg_pkg::node_msg_t msg;

    node_msg_pkg::node_msg_t exp_q [$];      // Expected messages in order
    logic [INPUTS-1:0]       live_m, pend_m; // Input state model
    int                      n_cmds = 0;

    node_top #(
          .INPUTS         (INPUTS)
        , .OUTPUTS        (OUTPUTS)
        , .STORE_DEPTH    (STORE_DEPTH)
    ) dut0 (
          .clk_i          (clk)
        , .arst_n_i       (arst_n)
        , .trigger_i      (trigger)
        , .map_i          (map)
        , .map_valid_i    (map_valid)
        , .sig_i          (sig)
        , .sig_valid_i    (sig_valid)
        , .node_row_i     (OWN_ROW)
        , .node_col_i     (OWN_COL)
        , .core_outputs_i (core_outputs)
        , .core_trigger_o (core_trigger)
        , .core_inputs_o  (core_inputs)
        , .idle_o         (idle)
        , .msg_o          (msg)
        , .msg_valid_o    (msg_valid)
        , .msg_ready_i    (msg_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    // ==================================================
    // Reporting
    // ==================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    // ==================================================
    // Command tasks start and end on a falling edge
    // ==================================================

    task automatic wait_idle();
        while (!idle) @(negedge clk);
    endtask

    task automatic write_mapping(input logic [2:0] out_idx, input logic [3:0] row,
                                 input logic [3:0] col, input logic [2:0] idx,
                                 input logic seq);
        wait_idle(); // Mappings only while idle
        map       = '{out_idx: out_idx, row: row, col: col, index: idx, is_seq: seq};
        map_valid = 1'b1;
        @(negedge clk);
        map_valid = 1'b0;
    endtask

    task automatic send_update(input logic [2:0] idx, input logic seq, input logic st);
        logic exp_pulse;
        exp_pulse   = !seq && (live_m[idx] != st); // Only a real flip triggers
        pend_m[idx] = st;
        if (!seq) live_m[idx] = st;
        sig       = '{index: idx, is_seq: seq, state: st};
        sig_valid = 1'b1;
        @(negedge clk);
        sig_valid = 1'b0;
        check_value("core_trigger_o", 32'(core_trigger), 32'(exp_pulse));
        check_value("core_inputs_o", 32'(core_inputs), 32'(live_m));
    endtask

    task automatic pulse_trigger();
        live_m  = pend_m; // Pending state goes live
        trigger = 1'b1;
        @(negedge clk);
        trigger = 1'b0;
        check_value("core_trigger_o", 32'(core_trigger), 32'd1);
        check_value("core_inputs_o", 32'(core_inputs), 32'(live_m));
    endtask

    task automatic set_outputs(input logic [OUTPUTS-1:0] vec);
        core_outputs = vec;
        @(negedge clk);
        wait_idle(); // Walks done and messages drained
    endtask

    task automatic push_expected(input logic [3:0] row, input logic [3:0] col,
                                 input logic [2:0] idx, input logic seq, input logic st);
        node_msg_pkg::node_msg_t m;
        m = '{row: row, col: col, index: idx, is_seq: seq, state: st};
        exp_q.push_back(m);
    endtask

    task automatic verify_inputs(input logic [INPUTS-1:0] vec);
        wait_idle();
        check_value("core_inputs_o", 32'(core_inputs), 32'(vec));
        live_m = vec; // Picks up loopback updates
    endtask

    // ==================================================
    // Back-pressure, scoreboard, watchdog
    // ==================================================

    initial begin
        forever begin
            @(negedge clk);
            msg_ready = ($urandom % 4) != 0; // Low about one cycle in four
        end
    end

    always @(posedge clk) begin
        node_msg_pkg::node_msg_t exp_msg;
        if (arst_n && msg_valid && msg_ready) begin
            if (exp_q.size() == 0) begin
                $display("Message %h sent at %0t when none was expected", msg, $time);
                abort_run("Unexpected message on the stream");
            end else begin
                exp_msg = exp_q.pop_front();
                check_value("msg_o", 32'(msg), 32'(exp_msg));
            end
        end
    end

    initial begin
        wait (n_cmds > 0);
        repeat (n_cmds * CMD_CYCLES + 20) @(posedge clk);
        abort_run("Timeout: the tests did not finish in the allowed cycles");
    end

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int          fd;
        string       line;
        string       cmd;
        string       lines [$];
        logic [31:0] a, b, c, d, e;
        void'($urandom(32'h747e_6553)); // One seed for the whole run
        arst_n       = 1'b0;
        trigger      = 1'b0;
        map_valid    = 1'b0;
        sig_valid    = 1'b0;
        msg_ready    = 1'b0;
        map          = '0;
        sig          = '0;
        core_outputs = '0;
        live_m       = '0;
        pend_m       = '0;

        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) abort_run("Could not open the test file");
        while ($fgets(line, fd) > 0) begin
            // Skip blank and comment lines
            if ($sscanf(line, "%s", cmd) == 1 && cmd.getc(0) != "#") lines.push_back(line);
        end
        $fclose(fd);
        n_cmds = lines.size(); // Starts the watchdog

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("idle_o", 32'(idle), 32'd1);
        check_value("msg_valid_o", 32'(msg_valid), 32'd0);
        check_value("core_trigger_o", 32'(core_trigger), 32'd0);
        check_value("core_inputs_o", 32'(core_inputs), 32'd0);

        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s %h %h %h %h %h", cmd, a, b, c, d, e));
            case (cmd)
                "MAP":    write_mapping(a[2:0], b[3:0], c[3:0], d[2:0], e[0]);
                "SIG":    send_update(a[2:0], b[0], c[0]);
                "TRIG":   pulse_trigger();
                "OUT":    set_outputs(a[OUTPUTS-1:0]);
                "EXPMSG": push_expected(a[3:0], b[3:0], c[2:0], d[0], e[0]);
                "EXPIN":  verify_inputs(a[INPUTS-1:0]);
                default:  abort_run({"Unknown command in the test file: ", cmd});
            endcase
        end

        wait_idle();
        if (exp_q.size() != 0) begin
            $display("%0d expected messages were never sent", exp_q.size());
            abort_run("Message stream ended early");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule : node_tb

//--- bench/node_tests.txt
# Hex fields. MAP out row col idx seq | SIG idx seq state | TRIG | OUT vector
# EXPMSG row col idx seq state (queued, put before OUT) | EXPIN input vector
SIG 1 0 1
SIG 1 0 1
SIG 0 0 1
EXPIN 03
SIG 4 1 1
EXPIN 03
TRIG
EXPIN 13
SIG 4 0 0
# Output 0 to three remote nodes, output 1 to two, output 2 to one
MAP 0 1 1 2 0
MAP 0 5 6 7 1
MAP 0 0 f 3 0
MAP 1 a b 1 0
MAP 1 4 4 6 1
MAP 2 7 0 0 1
EXPMSG 1 1 2 0 1
EXPMSG 5 6 7 1 1
EXPMSG 0 f 3 0 1
OUT 01
EXPMSG 1 1 2 0 0
EXPMSG 5 6 7 1 0
EXPMSG 0 f 3 0 0
OUT 00
# Outputs 0, 2 and unmapped 5 change together
EXPMSG 1 1 2 0 1
EXPMSG 5 6 7 1 1
EXPMSG 0 f 3 0 1
EXPMSG 7 0 0 1 1
OUT 25
EXPMSG a b 1 0 1
EXPMSG 4 4 6 1 1
OUT 27
# Output 3 loops back to input 6 and feeds one remote node
MAP 3 2 3 6 0
MAP 3 9 9 2 0
EXPMSG 9 9 2 0 1
OUT 2f
EXPIN 43
EXPMSG 9 9 2 0 0
OUT 27
EXPIN 03
SIG 6 0 1
TRIG
EXPIN 43

//--- compile.f
verilog/node_cfg_pkg.sv
verilog/node_msg_pkg.sv
verilog/output_store.sv
verilog/node_control_inputs.sv
verilog/node_control_outputs.sv
verilog/node_control.sv
verilog/node_top.sv
bench/node_tb.sv

//--- verilog/node_cfg_pkg.sv
/*
 * Node geometry and the layout of one mapping store entry.
 * Row, column and I/O index widths are fixed here for the whole mesh.
 */
package node_cfg_pkg;

    // ==================================================
    // Mesh geometry
    // ==================================================

    localparam int ROW_W = 4; // Node row address
    localparam int COL_W = 4; // Node column address
    localparam int IOR_W = 3; // Input or output index

    // ==================================================
    // Mapping store entry
    // ==================================================

    // One fan-out target of a core output
    typedef struct packed {
        logic             loopback; // Target is this node
        logic [ROW_W-1:0] row;      // Target row
        logic [COL_W-1:0] col;      // Target column
        logic [IOR_W-1:0] index;    // Target input index
        logic             is_seq;   // Target input is sequential
    } store_entry_t;

endpackage : node_cfg_pkg

//--- verilog/node_control.sv
/*
 * Node control. Writes mappings into the store and tracks per-output pointers.
 * Mappings for one output must be back to back and only while idle.
 * A walk owns the store address, writes take it otherwise.
 */
`timescale 1ns/1ps

module node_control #(
      parameter int INPUTS      = 8
    , parameter int OUTPUTS     = 8
    , parameter int STORE_DEPTH = 32
) (
      input  logic                             clk_i
    , input  logic                             arst_n_i
    , input  logic [node_cfg_pkg::ROW_W-1:0]   node_row_i
    , input  logic [node_cfg_pkg::COL_W-1:0]   node_col_i
    , input  logic                             trigger_i
    , input  node_msg_pkg::map_req_t           map_i
    , input  logic                             map_valid_i
    , input  node_msg_pkg::sig_upd_t           sig_i
    , input  logic                             sig_valid_i
    , input  logic [OUTPUTS-1:0]               core_outputs_i
    , output logic                             core_trigger_o
    , output logic [INPUTS-1:0]                core_inputs_o
    , output node_msg_pkg::node_msg_t          msg_o
    , output logic                             msg_valid_o
    , input  logic                             msg_ready_i
    , output logic [$clog2(STORE_DEPTH)-1:0]   store_addr_o
    , output logic                             store_wr_en_o
    , output node_cfg_pkg::store_entry_t       store_wr_data_o
    , output logic                             store_rd_en_o
    , input  node_cfg_pkg::store_entry_t       store_rd_data_i
    , output logic                             idle_o
);

    localparam int AW = $clog2(STORE_DEPTH);

    logic [OUTPUTS-1:0]         actv_q;
    logic [OUTPUTS-1:0][AW-1:0] base_q, final_q;
    logic [AW:0]                next_q;  // Extra bit catches overflow
    logic [AW-1:0]              rd_addr;
    logic                       rd_en, walk_idle;
    node_msg_pkg::sig_upd_t     loop;
    logic                       loop_valid;

    // ==================================================
    // Mapping writes
    // ==================================================

    assign store_wr_en_o   = map_valid_i; // Written on the next edge
    assign store_wr_data_o = '{
        loopback: (map_i.row == node_row_i) && (map_i.col == node_col_i),
        row:      map_i.row,
        col:      map_i.col,
        index:    map_i.index,
        is_seq:   map_i.is_seq
    };

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            actv_q  <= '0;
            base_q  <= '0;
            final_q <= '0;
            next_q  <= '0;
        end else if (map_valid_i) begin
            // First mapping of an output sets its base
            if (!actv_q[map_i.out_idx]) base_q[map_i.out_idx] <= next_q[AW-1:0];
            final_q[map_i.out_idx] <= next_q[AW-1:0];
            actv_q[map_i.out_idx]  <= 1'b1;
            next_q                 <= next_q + 1'b1;
        end
    end

    // Read wins the address, writes only happen while idle
    assign store_addr_o  = rd_en ? rd_addr : next_q[AW-1:0];
    assign store_rd_en_o = rd_en;

    // ==================================================
    // Sub-blocks
    // ==================================================

    node_control_inputs #(
        .INPUTS         (INPUTS)
    ) ctrl_inputs (
          .clk_i          (clk_i)
        , .arst_n_i       (arst_n_i)
        , .trigger_i      (trigger_i)
        , .sig_i          (sig_i)
        , .sig_valid_i    (sig_valid_i)
        , .loop_i         (loop)
        , .loop_valid_i   (loop_valid)
        , .core_trigger_o (core_trigger_o)
        , .core_inputs_o  (core_inputs_o)
    );

    node_control_outputs #(
          .OUTPUTS        (OUTPUTS)
        , .STORE_DEPTH    (STORE_DEPTH)
    ) ctrl_outputs (
          .clk_i          (clk_i)
        , .arst_n_i       (arst_n_i)
        , .core_outputs_i (core_outputs_i)
        , .out_actv_i     (actv_q)
        , .out_base_i     (base_q)
        , .out_final_i    (final_q)
        , .rd_addr_o      (rd_addr)
        , .rd_en_o        (rd_en)
        , .rd_data_i      (store_rd_data_i)
        , .msg_o          (msg_o)
        , .msg_valid_o    (msg_valid_o)
        , .msg_ready_i    (msg_ready_i)
        , .loop_o         (loop)
        , .loop_valid_o   (loop_valid)
        , .idle_o         (walk_idle)
    );

    assign idle_o = walk_idle && !core_trigger_o; // Trigger still in flight

    // A write during a walk would corrupt the held read data
    a_map_idle : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        map_valid_i |-> walk_idle
    );

    a_store_full : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        map_valid_i |-> (next_q < STORE_DEPTH)
    );

endmodule : node_control

//--- verilog/node_control_inputs.sv
/*
 * Collects input updates into the live core input vector.
 * The pending vector mirrors every update. A trigger copies it to live.
 * External and loopback updates in one cycle both apply, one trigger pulse.
 */
`timescale 1ns/1ps

module node_control_inputs #(
    parameter int INPUTS = 8
) (
      input  logic                   clk_i
    , input  logic                   arst_n_i
    , input  logic                   trigger_i
    , input  node_msg_pkg::sig_upd_t sig_i
    , input  logic                   sig_valid_i
    , input  node_msg_pkg::sig_upd_t loop_i
    , input  logic                   loop_valid_i
    , output logic                   core_trigger_o
    , output logic [INPUTS-1:0]      core_inputs_o
);

    // ==================================================
    // State
    // ==================================================

    logic [INPUTS-1:0]      live_q, live_d; // Drives the core
    logic [INPUTS-1:0]      pend_q, pend_d; // Next state incl. sequential
    logic                   trig_q;
    logic                   change;         // Real combinational change
    node_msg_pkg::sig_upd_t upd [2];
    logic                   upd_vld [2];

    assign upd[0]     = sig_i;
    assign upd[1]     = loop_i;
    assign upd_vld[0] = sig_valid_i;
    assign upd_vld[1] = loop_valid_i;

    // ==================================================
    // Update rules
    // ==================================================

    always_comb begin
        live_d = live_q;
        pend_d = pend_q;
        change = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (upd_vld[i]) begin
                pend_d[upd[i].index] = upd[i].state;
                if (!upd[i].is_seq) begin
                    // Only a flipped bit restarts the core
                    if (live_q[upd[i].index] != upd[i].state) change = 1'b1;
                    live_d[upd[i].index] = upd[i].state;
                end
            end
        end
        if (trigger_i) live_d = pend_d; // Release sequential state
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            live_q <= '0;
            pend_q <= '0;
            trig_q <= 1'b0;
        end else begin
            live_q <= live_d;
            pend_q <= pend_d;
            trig_q <= trigger_i || change; // Single cycle pulse
        end
    end

    assign core_inputs_o  = live_q;
    assign core_trigger_o = trig_q;

    // Loopback index comes from the mapping store
    a_index_range : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (sig_valid_i |-> sig_i.index < INPUTS) and
        (loop_valid_i |-> loop_i.index < INPUTS)
    );

endmodule : node_control_inputs

//--- verilog/node_control_outputs.sv
/*
 * Walks the mapping entries of each changed output, lowest index first.
 * One entry costs a read cycle plus a send cycle, longer under back-pressure.
 * Relies on the store holding its read data until the next read.
 */
`timescale 1ns/1ps

module node_control_outputs #(
      parameter int OUTPUTS     = 8
    , parameter int STORE_DEPTH = 32
) (
      input  logic                                         clk_i
    , input  logic                                         arst_n_i
    , input  logic [OUTPUTS-1:0]                           core_outputs_i
    , input  logic [OUTPUTS-1:0]                           out_actv_i
    , input  logic [OUTPUTS-1:0][$clog2(STORE_DEPTH)-1:0]  out_base_i
    , input  logic [OUTPUTS-1:0][$clog2(STORE_DEPTH)-1:0]  out_final_i
    , output logic [$clog2(STORE_DEPTH)-1:0]               rd_addr_o
    , output logic                                         rd_en_o
    , input  node_cfg_pkg::store_entry_t                   rd_data_i
    , output node_msg_pkg::node_msg_t                      msg_o
    , output logic                                         msg_valid_o
    , input  logic                                         msg_ready_i
    , output node_msg_pkg::sig_upd_t                       loop_o
    , output logic                                         loop_valid_o
    , output logic                                         idle_o
);

    localparam int AW    = $clog2(STORE_DEPTH);
    localparam int SEL_W = $clog2(OUTPUTS);

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_READ, // Store read issued
        WALK_SEND  // Entry on rd_data_i
    } walk_t;

    walk_t              state_q;
    logic [OUTPUTS-1:0] last_q;     // Last sent output values
    logic [OUTPUTS-1:0] changed;
    logic [SEL_W-1:0]   sel;
    logic [AW-1:0]      cur_q, fin_q;
    logic               val_q;      // Value carried by this walk
    logic               start, send_done;

    // ==================================================
    // Change detect and priority pick
    // ==================================================

    assign changed = (core_outputs_i ^ last_q) & out_actv_i; // Unmapped ignored

    always_comb begin
        sel = '0;
        for (int i = OUTPUTS - 1; i >= 0; i--) begin
            if (changed[i]) sel = SEL_W'(i); // Lowest wins
        end
    end

    assign start     = (state_q == WALK_IDLE) && (|changed);
    assign send_done = (state_q == WALK_SEND) && (rd_data_i.loopback || msg_ready_i);

    // ==================================================
    // Walk FSM
    // ==================================================

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= WALK_IDLE;
            last_q  <= '0;
        end else begin
            case (state_q)
                WALK_IDLE: begin
                    if (start) begin
                        last_q[sel] <= core_outputs_i[sel]; // Taken at walk start
                        state_q     <= WALK_READ;
                    end
                end
                WALK_READ: state_q <= WALK_SEND;
                WALK_SEND: begin
                    if (send_done) state_q <= (cur_q == fin_q) ? WALK_IDLE : WALK_READ;
                end
                default: state_q <= WALK_IDLE;
            endcase
        end
    end

    // Walk pointers and carried value
    always_ff @(posedge clk_i) begin
        if (start) begin
            cur_q <= out_base_i[sel];
            fin_q <= out_final_i[sel];
            val_q <= core_outputs_i[sel];
        end else if (send_done) begin
            cur_q <= cur_q + 1'b1; // Entries of one output are contiguous
        end
    end

    // ==================================================
    // Store read and outbound paths
    // ==================================================

    assign rd_addr_o = cur_q;
    assign rd_en_o   = (state_q == WALK_READ);

    assign msg_o = '{row: rd_data_i.row, col: rd_data_i.col, index: rd_data_i.index,
                     is_seq: rd_data_i.is_seq, state: val_q};
    assign msg_valid_o = (state_q == WALK_SEND) && !rd_data_i.loopback;

    assign loop_o       = '{index: rd_data_i.index, is_seq: rd_data_i.is_seq, state: val_q};
    assign loop_valid_o = (state_q == WALK_SEND) && rd_data_i.loopback; // Never stalls

    assign idle_o = (state_q == WALK_IDLE) && !(|changed);

    // Store data must hold across the stall
    a_msg_hold : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (msg_valid_o && !msg_ready_i) |=> (msg_valid_o && $stable(msg_o))
    );

endmodule : node_control_outputs

//--- verilog/node_msg_pkg.sv
/*
 * Request, update and message words seen at the node boundary.
 * Field widths come from node_cfg_pkg, so compile that package first.
 */
package node_msg_pkg;

    // Mapping request for one output
    typedef struct packed {
        logic [node_cfg_pkg::IOR_W-1:0] out_idx; // Output being mapped
        logic [node_cfg_pkg::ROW_W-1:0] row;
        logic [node_cfg_pkg::COL_W-1:0] col;
        logic [node_cfg_pkg::IOR_W-1:0] index;   // Target input
        logic                           is_seq;
    } map_req_t;

    // Signal update, external or loopback
    typedef struct packed {
        logic [node_cfg_pkg::IOR_W-1:0] index;
        logic                           is_seq; // Held until trigger
        logic                           state;
    } sig_upd_t;

    // Outbound message to a remote node
    typedef struct packed {
        logic [node_cfg_pkg::ROW_W-1:0] row;
        logic [node_cfg_pkg::COL_W-1:0] col;
        logic [node_cfg_pkg::IOR_W-1:0] index;
        logic                           is_seq;
        logic                           state; // New output value
    } node_msg_t;

endpackage : node_msg_pkg

//--- verilog/node_top.sv
/*
 * Node top. Control block plus its mapping store.
 * INPUTS, OUTPUTS and STORE_DEPTH are set here only.
 */
`timescale 1ns/1ps

module node_top #(
      parameter int INPUTS      = 8
    , parameter int OUTPUTS     = 8
    , parameter int STORE_DEPTH = 32
) (
      input  logic                           clk_i
    , input  logic                           arst_n_i
    // Strobes
    , input  logic                           trigger_i
    , input  node_msg_pkg::map_req_t         map_i
    , input  logic                           map_valid_i
    , input  node_msg_pkg::sig_upd_t         sig_i
    , input  logic                           sig_valid_i
    // Levels
    , input  logic [node_cfg_pkg::ROW_W-1:0] node_row_i
    , input  logic [node_cfg_pkg::COL_W-1:0] node_col_i
    , input  logic [OUTPUTS-1:0]             core_outputs_i
    // Core side
    , output logic                           core_trigger_o
    , output logic [INPUTS-1:0]              core_inputs_o
    , output logic                           idle_o
    // Message stream
    , output node_msg_pkg::node_msg_t        msg_o
    , output logic                           msg_valid_o
    , input  logic                           msg_ready_i
);

    logic [$clog2(STORE_DEPTH)-1:0] store_addr;
    logic                           store_wr_en, store_rd_en;
    node_cfg_pkg::store_entry_t     store_wr_data, store_rd_data;

    node_control #(
          .INPUTS          (INPUTS)
        , .OUTPUTS         (OUTPUTS)
        , .STORE_DEPTH     (STORE_DEPTH)
    ) ctrl (
          .clk_i           (clk_i)
        , .arst_n_i        (arst_n_i)
        , .node_row_i      (node_row_i)
        , .node_col_i      (node_col_i)
        , .trigger_i       (trigger_i)
        , .map_i           (map_i)
        , .map_valid_i     (map_valid_i)
        , .sig_i           (sig_i)
        , .sig_valid_i     (sig_valid_i)
        , .core_outputs_i  (core_outputs_i)
        , .core_trigger_o  (core_trigger_o)
        , .core_inputs_o   (core_inputs_o)
        , .msg_o           (msg_o)
        , .msg_valid_o     (msg_valid_o)
        , .msg_ready_i     (msg_ready_i)
        , .store_addr_o    (store_addr)
        , .store_wr_en_o   (store_wr_en)
        , .store_wr_data_o (store_wr_data)
        , .store_rd_en_o   (store_rd_en)
        , .store_rd_data_i (store_rd_data)
        , .idle_o          (idle_o)
    );

    output_store #(
        .STORE_DEPTH (STORE_DEPTH)
    ) store (
          .clk_i     (clk_i)
        , .arst_n_i  (arst_n_i)
        , .addr_i    (store_addr)
        , .wr_en_i   (store_wr_en)
        , .wr_data_i (store_wr_data)
        , .rd_en_i   (store_rd_en)
        , .rd_data_o (store_rd_data)
    );

endmodule : node_top

//--- verilog/output_store.sv
/*
 * Single-port mapping store. Read data is registered and appears one
 * cycle after rd_en_i, then holds until the next read.
 * Write and read must not be enabled together.
 */
`timescale 1ns/1ps

module output_store #(
    parameter int STORE_DEPTH = 32
) (
      input  logic                             clk_i
    , input  logic                             arst_n_i
    , input  logic [$clog2(STORE_DEPTH)-1:0]   addr_i
    , input  logic                             wr_en_i
    , input  node_cfg_pkg::store_entry_t       wr_data_i
    , input  logic                             rd_en_i
    , output node_cfg_pkg::store_entry_t       rd_data_o
);

    node_cfg_pkg::store_entry_t mem [STORE_DEPTH]; // Entry array

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[addr_i] <= wr_data_i;
        end
        if (rd_en_i) begin
            rd_data_o <= mem[addr_i]; // Held while idle
        end
    end

    // Non power-of-two depths leave unused addresses
    a_addr_range : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (wr_en_i || rd_en_i) |-> (addr_i < STORE_DEPTH)
    );

endmodule : output_store
